//--- hw/segre_pkg.sv
package segre_pkg;

    localparam int WORD_SIZE = 32;
    localparam int REG_SIZE  = 5;

    typedef enum logic [1:0] {
        IF_STATE,
        ID_STATE,
        EX_STATE,
        WB_STATE
    } fsm_state_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        // Passes operand b straight through
        ALU_LUI
    } alu_opcode_e;

    typedef enum logic [1:0] {
        ALU_A_REG,
        ALU_A_IMM,
        ALU_A_PC
    } alu_src_a_e;

    typedef enum logic {
        ALU_B_REG,
        ALU_B_IMM
    } alu_src_b_e;

    typedef enum logic [2:0] {
        IMM_B_U,
        IMM_B_I,
        IMM_B_S,
        IMM_B_J,
        IMM_B_B
    } alu_imm_b_e;

    typedef enum logic {
        BR_A_REG,
        BR_A_PC
    } br_src_a_e;

    typedef enum logic {
        BR_B_REG
    } br_src_b_e;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } memop_data_type_e;

    // Decoded instruction handed to execute
    typedef struct packed {
        logic                 valid;
        alu_opcode_e          alu_opcode;
        logic [WORD_SIZE-1:0] alu_src_a;
        logic [WORD_SIZE-1:0] alu_src_b;
        logic                 rf_we;
        logic [REG_SIZE-1:0]  rf_waddr;
        memop_data_type_e     memop_type;
        logic                 memop_sign_ext;
        logic                 memop_rd;
        logic                 memop_wr;
        logic [WORD_SIZE-1:0] memop_rf_data;
        logic [WORD_SIZE-1:0] br_src_a;
        logic [WORD_SIZE-1:0] br_src_b;
    } id_ex_t;

    typedef struct packed {
        logic                 we;
        logic [REG_SIZE-1:0]  waddr;
        logic [WORD_SIZE-1:0] wdata;
    } rf_wr_t;

endpackage

//--- hw/segre_decode.sv
module segre_decode (
    input  logic [segre_pkg::WORD_SIZE-1:0] instr_i,
    output logic [segre_pkg::WORD_SIZE-1:0] imm_u_o,
    output logic [segre_pkg::WORD_SIZE-1:0] imm_i_o,
    output logic [segre_pkg::WORD_SIZE-1:0] imm_s_o,
    output logic [segre_pkg::WORD_SIZE-1:0] imm_j_o,
    output logic [segre_pkg::WORD_SIZE-1:0] imm_b_o,
    output segre_pkg::alu_opcode_e          alu_opcode_o,
    output segre_pkg::alu_src_a_e           src_a_sel_o,
    output segre_pkg::alu_src_b_e           src_b_sel_o,
    output segre_pkg::alu_imm_b_e           imm_b_sel_o,
    output segre_pkg::br_src_a_e            br_a_sel_o,
    output segre_pkg::br_src_b_e            br_b_sel_o,
    output logic [segre_pkg::REG_SIZE-1:0]  raddr_a_o,
    output logic [segre_pkg::REG_SIZE-1:0]  raddr_b_o,
    output logic [segre_pkg::REG_SIZE-1:0]  waddr_o,
    output logic                            rf_we_o,
    output segre_pkg::memop_data_type_e     memop_type_o,
    output logic                            memop_rd_o,
    output logic                            memop_wr_o,
    output logic                            memop_sign_ext_o
);
    import segre_pkg::*;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic             funct7_b5;
    memop_data_type_e mem_width;

    // alt picks SUB over ADD and SRA over SRL
    function automatic alu_opcode_e alu_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
    endfunction

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];

    assign raddr_a_o = instr_i[19:15];
    assign raddr_b_o = instr_i[24:20];
    assign waddr_o   = instr_i[11:7];

    assign imm_u_o = {instr_i[31:12], 12'b0};
    assign imm_i_o = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_j_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
    assign imm_b_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

    assign mem_width = (funct3[1:0] == 2'b00) ? BYTE :
                       (funct3[1:0] == 2'b01) ? HALF : WORD;

    always_comb begin
        alu_opcode_o     = ALU_ADD;
        src_a_sel_o      = ALU_A_REG;
        src_b_sel_o      = ALU_B_REG;
        imm_b_sel_o      = IMM_B_I;
        br_a_sel_o       = BR_A_REG;
        br_b_sel_o       = BR_B_REG;
        rf_we_o          = 1'b0;
        memop_type_o     = BYTE;
        memop_rd_o       = 1'b0;
        memop_wr_o       = 1'b0;
        memop_sign_ext_o = 1'b0;
        case (opcode)
            OPC_LUI: begin
                alu_opcode_o = ALU_LUI;
                src_a_sel_o  = ALU_A_IMM;
                src_b_sel_o  = ALU_B_IMM;
                imm_b_sel_o  = IMM_B_U;
                rf_we_o      = 1'b1;
            end
            OPC_AUIPC: begin
                src_a_sel_o = ALU_A_PC;
                src_b_sel_o = ALU_B_IMM;
                imm_b_sel_o = IMM_B_U;
                rf_we_o     = 1'b1;
            end
            OPC_JAL: begin
                src_a_sel_o = ALU_A_PC;
                src_b_sel_o = ALU_B_IMM;
                imm_b_sel_o = IMM_B_J;
                br_a_sel_o  = BR_A_PC;
                rf_we_o     = 1'b1;
            end
            OPC_JALR: begin
                src_b_sel_o = ALU_B_IMM;
                br_a_sel_o  = BR_A_PC;
                rf_we_o     = 1'b1;
            end
            // Target on the ALU, comparison on the branch operands
            OPC_BRANCH: begin
                src_a_sel_o = ALU_A_PC;
                src_b_sel_o = ALU_B_IMM;
                imm_b_sel_o = IMM_B_B;
            end
            OPC_LOAD: begin
                src_b_sel_o      = ALU_B_IMM;
                rf_we_o          = 1'b1;
                memop_type_o     = mem_width;
                memop_rd_o       = 1'b1;
                memop_sign_ext_o = ~funct3[2];
            end
            OPC_STORE: begin
                src_b_sel_o  = ALU_B_IMM;
                imm_b_sel_o  = IMM_B_S;
                memop_type_o = mem_width;
                memop_wr_o   = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_opcode_o = alu_op(funct3, funct7_b5 && (funct3 == 3'b101));
                src_b_sel_o  = ALU_B_IMM;
                rf_we_o      = 1'b1;
            end
            OPC_OP: begin
                alu_opcode_o = alu_op(funct3, funct7_b5);
                rf_we_o      = 1'b1;
            end
            default: ;
        endcase
    end

    a_rd_wr_excl: assert final (!(memop_rd_o && memop_wr_o));

endmodule

//--- hw/segre_register_file.sv
module segre_register_file (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic [segre_pkg::REG_SIZE-1:0]  raddr_a_i,
    input  logic [segre_pkg::REG_SIZE-1:0]  raddr_b_i,
    input  segre_pkg::rf_wr_t               rf_wr_i,
    output logic [segre_pkg::WORD_SIZE-1:0] data_a_o,
    output logic [segre_pkg::WORD_SIZE-1:0] data_b_o
);
    import segre_pkg::*;

    localparam int NUM_REGS = 2 ** REG_SIZE;

    logic [WORD_SIZE-1:0] regs_q [NUM_REGS];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (rf_wr_i.we && (rf_wr_i.waddr != '0)) begin
            // x0 is never written, so it keeps its reset zero
            regs_q[rf_wr_i.waddr] <= rf_wr_i.wdata;
        end
    end

    assign data_a_o = regs_q[raddr_a_i];
    assign data_b_o = regs_q[raddr_b_i];

endmodule

//--- hw/segre_controller.sv
module segre_controller #(
    parameter logic [segre_pkg::WORD_SIZE-1:0] PC_RESET = '0
) (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic [segre_pkg::WORD_SIZE-1:0] instr_i,
    input  logic                            instr_valid_i,
    output segre_pkg::fsm_state_e           fsm_state_o,
    output logic [segre_pkg::WORD_SIZE-1:0] instr_o,
    output logic [segre_pkg::WORD_SIZE-1:0] pc_o
);
    import segre_pkg::*;

    fsm_state_e           state_q;
    fsm_state_e           state_d;
    logic                 accept;
    logic [WORD_SIZE-1:0] instr_q;
    logic [WORD_SIZE-1:0] pc_q;
    logic [WORD_SIZE-1:0] next_pc_q;

    // Strobes outside IF are dropped
    assign accept = (state_q == IF_STATE) && instr_valid_i;

    always_comb begin
        case (state_q)
            IF_STATE: state_d = accept ? ID_STATE : IF_STATE;
            ID_STATE: state_d = EX_STATE;
            EX_STATE: state_d = WB_STATE;
            default:  state_d = IF_STATE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= IF_STATE;
            instr_q   <= '0;
            pc_q      <= PC_RESET;
            next_pc_q <= PC_RESET;
        end else begin
            state_q <= state_d;
            if (accept) begin
                instr_q   <= instr_i;
                pc_q      <= next_pc_q;
                next_pc_q <= next_pc_q + WORD_SIZE'(4);
            end
        end
    end

    assign fsm_state_o = state_q;
    assign instr_o     = instr_q;
    assign pc_o        = pc_q;

    a_if_to_id: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        state_q == IF_STATE |=> state_q inside {IF_STATE, ID_STATE});

endmodule

//--- hw/segre_id_stage.sv
module segre_id_stage (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  segre_pkg::fsm_state_e           fsm_state_i,
    input  logic [segre_pkg::WORD_SIZE-1:0] instr_i,
    input  logic [segre_pkg::WORD_SIZE-1:0] pc_i,
    output logic [segre_pkg::REG_SIZE-1:0]  rf_raddr_a_o,
    output logic [segre_pkg::REG_SIZE-1:0]  rf_raddr_b_o,
    input  logic [segre_pkg::WORD_SIZE-1:0] rf_data_a_i,
    input  logic [segre_pkg::WORD_SIZE-1:0] rf_data_b_i,
    output segre_pkg::id_ex_t               id_ex_o
);
    import segre_pkg::*;

    logic [WORD_SIZE-1:0] imm_u;
    logic [WORD_SIZE-1:0] imm_i;
    logic [WORD_SIZE-1:0] imm_s;
    logic [WORD_SIZE-1:0] imm_j;
    logic [WORD_SIZE-1:0] imm_b;
    logic [WORD_SIZE-1:0] imm_sel;
    alu_opcode_e          alu_opcode;
    alu_src_a_e           src_a_sel;
    alu_src_b_e           src_b_sel;
    alu_imm_b_e           imm_b_sel;
    br_src_a_e            br_a_sel;
    br_src_b_e            br_b_sel;
    logic [REG_SIZE-1:0]  waddr;
    logic                 rf_we;
    memop_data_type_e     memop_type;
    logic                 memop_rd;
    logic                 memop_wr;
    logic                 memop_sign_ext;
    logic                 in_id;
    id_ex_t               id_ex_d;
    id_ex_t               id_ex_q;

    segre_decode i_decode (
        .instr_i          (instr_i),
        .imm_u_o          (imm_u),
        .imm_i_o          (imm_i),
        .imm_s_o          (imm_s),
        .imm_j_o          (imm_j),
        .imm_b_o          (imm_b),
        .alu_opcode_o     (alu_opcode),
        .src_a_sel_o      (src_a_sel),
        .src_b_sel_o      (src_b_sel),
        .imm_b_sel_o      (imm_b_sel),
        .br_a_sel_o       (br_a_sel),
        .br_b_sel_o       (br_b_sel),
        .raddr_a_o        (rf_raddr_a_o),
        .raddr_b_o        (rf_raddr_b_o),
        .waddr_o          (waddr),
        .rf_we_o          (rf_we),
        .memop_type_o     (memop_type),
        .memop_rd_o       (memop_rd),
        .memop_wr_o       (memop_wr),
        .memop_sign_ext_o (memop_sign_ext)
    );

    assign in_id = (fsm_state_i == ID_STATE);

    always_comb begin
        case (imm_b_sel)
            IMM_B_U: imm_sel = imm_u;
            IMM_B_S: imm_sel = imm_s;
            IMM_B_J: imm_sel = imm_j;
            IMM_B_B: imm_sel = imm_b;
            default: imm_sel = imm_i;
        endcase
    end

    always_comb begin
        id_ex_d.valid      = in_id;
        id_ex_d.alu_opcode = alu_opcode;
        case (src_a_sel)
            ALU_A_PC:  id_ex_d.alu_src_a = pc_i;
            ALU_A_IMM: id_ex_d.alu_src_a = '0;
            default:   id_ex_d.alu_src_a = rf_data_a_i;
        endcase
        id_ex_d.alu_src_b      = (src_b_sel == ALU_B_IMM) ? imm_sel : rf_data_b_i;
        // Strobes only live for the cycle after ID
        id_ex_d.rf_we          = rf_we && in_id;
        id_ex_d.rf_waddr       = waddr;
        id_ex_d.memop_type     = memop_type;
        id_ex_d.memop_sign_ext = memop_sign_ext;
        id_ex_d.memop_rd       = memop_rd && in_id;
        id_ex_d.memop_wr       = memop_wr && in_id;
        id_ex_d.memop_rf_data  = rf_data_b_i;
        id_ex_d.br_src_a       = (br_a_sel == BR_A_PC) ? pc_i : rf_data_a_i;
        id_ex_d.br_src_b       = (br_b_sel == BR_B_REG) ? rf_data_b_i : '0;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    assign id_ex_o = id_ex_q;

    a_valid_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        id_ex_q.valid |=> !id_ex_q.valid);

endmodule

//--- hw/segre_decode_top.sv
module segre_decode_top #(
    parameter logic [segre_pkg::WORD_SIZE-1:0] PC_RESET = '0
) (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic [segre_pkg::WORD_SIZE-1:0] instr_i,
    input  logic                            instr_valid_i,
    input  segre_pkg::rf_wr_t               rf_wr_i,
    output segre_pkg::id_ex_t               id_ex_o,
    output segre_pkg::fsm_state_e           fsm_state_o
);
    import segre_pkg::*;

    fsm_state_e           fsm_state;
    logic [WORD_SIZE-1:0] instr;
    logic [WORD_SIZE-1:0] pc;
    logic [REG_SIZE-1:0]  raddr_a;
    logic [REG_SIZE-1:0]  raddr_b;
    logic [WORD_SIZE-1:0] data_a;
    logic [WORD_SIZE-1:0] data_b;

    segre_controller #(
        .PC_RESET (PC_RESET)
    ) i_controller (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .fsm_state_o   (fsm_state),
        .instr_o       (instr),
        .pc_o          (pc)
    );

    segre_id_stage i_id_stage (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .fsm_state_i  (fsm_state),
        .instr_i      (instr),
        .pc_i         (pc),
        .rf_raddr_a_o (raddr_a),
        .rf_raddr_b_o (raddr_b),
        .rf_data_a_i  (data_a),
        .rf_data_b_i  (data_b),
        .id_ex_o      (id_ex_o)
    );

    // Write port is driven from outside the core
    segre_register_file i_register_file (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .raddr_a_i (raddr_a),
        .raddr_b_i (raddr_b),
        .rf_wr_i   (rf_wr_i),
        .data_a_o  (data_a),
        .data_b_o  (data_b)
    );

    assign fsm_state_o = fsm_state;

endmodule

//--- tests/segre_clkgen.sv
module segre_clkgen (
    output logic clk_o,
    output logic arst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 4;

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // Released just after an edge so no flop sees it change
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 arst_n_o = 1'b1;
    end

endmodule

//--- tests/segre_tb.sv
module segre_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import segre_pkg::*;

    localparam logic [WORD_SIZE-1:0] PC_RESET = 32'h0000_0200;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam int NUM_INSTR  = 19;
    // Reset, register loads and waits for IF
    localparam int MARGIN     = 100;
    localparam int MAX_CYCLES = NUM_INSTR * 4 + MARGIN;

    logic                 clk;
    logic                 arst_n;
    logic [WORD_SIZE-1:0] instr_i;
    logic                 instr_valid_i;
    rf_wr_t               rf_wr_i;
    id_ex_t               id_ex_o;
    fsm_state_e           fsm_state_o;

    logic [WORD_SIZE-1:0] reg_model [32];
    logic [WORD_SIZE-1:0] pc_model;
    logic [31:0]          rng_state;
    int                   id_errors;
    int                   state_errors;
    int                   cycles;

    segre_clkgen i_clkgen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    segre_decode_top #(
        .PC_RESET (PC_RESET)
    ) i_segre_decode_top (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .rf_wr_i       (rf_wr_i),
        .id_ex_o       (id_ex_o),
        .fsm_state_o   (fsm_state_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // RV32I funct3 mapping, alt is instruction bit 30
    function automatic alu_opcode_e expected_alu_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic id_ex_t ref_decode(input logic [31:0] ins, input logic [31:0] pc);
        id_ex_t      e;
        logic [31:0] rs1v;
        logic [31:0] rs2v;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        rs1v  = reg_model[ins[19:15]];
        rs2v  = reg_model[ins[24:20]];
        imm_i = 32'($signed(ins[31:20]));
        imm_s = 32'($signed({ins[31:25], ins[11:7]}));
        imm_b = 32'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
        imm_u = {ins[31:12], 12'h000};
        imm_j = 32'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
        e               = '0;
        e.valid         = 1'b1;
        e.alu_opcode    = ALU_ADD;
        e.alu_src_a     = rs1v;
        e.alu_src_b     = rs2v;
        e.rf_waddr      = ins[11:7];
        e.memop_type    = BYTE;
        e.memop_rf_data = rs2v;
        e.br_src_a      = rs1v;
        e.br_src_b      = rs2v;
        case (ins[6:0])
            7'b0110111: begin
                e.alu_opcode = ALU_LUI;
                e.alu_src_a  = '0;
                e.alu_src_b  = imm_u;
                e.rf_we      = 1'b1;
            end
            7'b0010111: begin
                e.alu_src_a = pc;
                e.alu_src_b = imm_u;
                e.rf_we     = 1'b1;
            end
            7'b1101111: begin
                e.alu_src_a = pc;
                e.alu_src_b = imm_j;
                e.br_src_a  = pc;
                e.rf_we     = 1'b1;
            end
            7'b1100111: begin
                e.alu_src_b = imm_i;
                e.br_src_a  = pc;
                e.rf_we     = 1'b1;
            end
            7'b1100011: begin
                e.alu_src_a = pc;
                e.alu_src_b = imm_b;
            end
            7'b0000011, 7'b0100011: begin
                e.memop_type = (ins[13:12] == 2'b00) ? BYTE :
                               (ins[13:12] == 2'b01) ? HALF : WORD;
                e.memop_rd = ~ins[5];
                e.memop_wr = ins[5];
                e.rf_we    = ~ins[5];
                e.alu_src_b = ins[5] ? imm_s : imm_i;
                e.memop_sign_ext = ~ins[5] & ~ins[14];
            end
            7'b0010011: begin
                e.alu_opcode = expected_alu_op(ins[14:12], ins[30] && ins[14:12] == 3'b101);
                e.alu_src_b  = imm_i;
                e.rf_we      = 1'b1;
            end
            7'b0110011: begin
                e.alu_opcode = expected_alu_op(ins[14:12], ins[30]);
                e.rf_we      = 1'b1;
            end
            default: ;
        endcase
        return e;
    endfunction

    function automatic id_ex_t strobes_of(input id_ex_t v);
        id_ex_t s;
        s          = '0;
        s.valid    = v.valid;
        s.rf_we    = v.rf_we;
        s.memop_rd = v.memop_rd;
        s.memop_wr = v.memop_wr;
        return s;
    endfunction

    task automatic compare_id_ex(input string name, input id_ex_t exp, input id_ex_t act);
        if (exp !== act) begin
            $display("Error %s: expected %h actual %h", name, exp, act);
            id_errors++;
        end
    endtask

    task automatic compare_state(input string name, input fsm_state_e exp,
                                 input fsm_state_e act);
        if (exp !== act) begin
            $display("Error %s: expected %s actual %s", name, exp.name(), act.name());
            state_errors++;
        end
    endtask

    // Every drive and every check happens 1 ns after a rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        rf_wr_i.we    = 1'b1;
        rf_wr_i.waddr = addr;
        rf_wr_i.wdata = data;
        step();
        rf_wr_i.we = 1'b0;
        if (addr != 5'd0) begin
            reg_model[addr] = data;
        end
    endtask

    task automatic run_instr(input string name, input logic [31:0] instr);
        id_ex_t exp;
        while (fsm_state_o != IF_STATE) begin
            step();
        end
        exp           = ref_decode(instr, pc_model);
        instr_i       = instr;
        instr_valid_i = 1'b1;
        step();
        instr_valid_i = 1'b0;
        compare_state({name, "_id"}, ID_STATE, fsm_state_o);
        step();
        compare_state({name, "_ex"}, EX_STATE, fsm_state_o);
        compare_id_ex(name, exp, id_ex_o);
        pc_model = pc_model + 32'd4;
        step();
        compare_state({name, "_wb"}, WB_STATE, fsm_state_o);
        compare_id_ex({name, "_gate"}, '0, strobes_of(id_ex_o));
    endtask

    task automatic test_reset();
        compare_state("reset", IF_STATE, fsm_state_o);
        compare_id_ex("reset", '0, id_ex_o);
        run_instr("reset_addi", i_type(12'h001, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        step();
        compare_state("reset_back_to_if", IF_STATE, fsm_state_o);
        instr_i       = i_type(12'h002, 5'd0, 3'b000, 5'd2, OPC_OP_IMM);
        instr_valid_i = 1'b1;
        step();
        instr_valid_i = 1'b0;
        pc_model      = pc_model + 32'd4;
        step();
        compare_state("ex_strobe_ex", EX_STATE, fsm_state_o);
        // A second strobe arriving in EX must be dropped
        instr_valid_i = 1'b1;
        step();
        instr_valid_i = 1'b0;
        compare_state("ex_strobe_wb", WB_STATE, fsm_state_o);
        step();
        compare_state("ex_strobe_if", IF_STATE, fsm_state_o);
        // PC must not have moved for the dropped strobe
        run_instr("ex_strobe_auipc", {20'h00abc, 5'd3, 7'b0010111});
    endtask

    task automatic test_alu();
        for (int i = 1; i <= 10; i++) begin
            write_reg(5'(i), next_rand());
        end
        write_reg(5'd0, next_rand());
        run_instr("add", r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd11, OPC_OP));
        run_instr("sub", r_type(7'h20, 5'd4, 5'd3, 3'b000, 5'd12, OPC_OP));
        run_instr("xor", r_type(7'h00, 5'd6, 5'd5, 3'b100, 5'd13, OPC_OP));
        run_instr("sltu", r_type(7'h00, 5'd8, 5'd7, 3'b011, 5'd14, OPC_OP));
        run_instr("addi", i_type(12'(next_rand() >> 20), 5'd9, 3'b000, 5'd15, OPC_OP_IMM));
        run_instr("add_x0", r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd16, OPC_OP));
    endtask

    task automatic test_upper_jump();
        logic [31:0] r;
        r = next_rand();
        run_instr("lui", {r[31:12], 5'd17, 7'b0110111});
        r = next_rand();
        run_instr("auipc", {r[31:12], 5'd18, 7'b0010111});
        r = next_rand();
        run_instr("jal", {r[31:12], 5'd1, 7'b1101111});
    endtask

    task automatic test_mem();
        logic [31:0] r;
        r = next_rand();
        run_instr("lb", i_type(r[11:0], 5'd1, 3'b000, 5'd19, OPC_LOAD));
        run_instr("lhu", i_type(r[23:12], 5'd2, 3'b101, 5'd20, OPC_LOAD));
        r = next_rand();
        run_instr("lw", i_type(r[11:0], 5'd3, 3'b010, 5'd21, OPC_LOAD));
        r = next_rand();
        run_instr("sw", {r[31:25], 5'd5, 5'd4, 3'b010, r[4:0], 7'b0100011});
    endtask

    task automatic test_branch();
        logic [31:0] r;
        r = next_rand();
        run_instr("beq", {r[31:25], 5'd2, 5'd1, 3'b000, r[11:7], 7'b1100011});
        r = next_rand();
        run_instr("blt", {r[31:25], 5'd7, 5'd6, 3'b100, r[11:7], 7'b1100011});
    endtask

    task automatic test_unknown();
        logic [31:0] r;
        r = next_rand();
        run_instr("unknown", {r[31:7], 7'b1111111});
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        instr_i       = '0;
        instr_valid_i = 1'b0;
        rf_wr_i       = '0;
        pc_model      = PC_RESET;
        rng_state     = 32'h8f46;
        id_errors     = 0;
        state_errors  = 0;
        cycles        = 0;
        foreach (reg_model[i]) begin
            reg_model[i] = '0;
        end
        wait (arst_n == 1'b1);
        test_reset();
        test_alu();
        test_upper_jump();
        test_mem();
        test_branch();
        test_unknown();
        $display("Errors: %0d decode, %0d state", id_errors, state_errors);
        if (id_errors == 0 && state_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sources.f
hw/segre_pkg.sv
hw/segre_decode.sv
hw/segre_register_file.sv
hw/segre_controller.sv
hw/segre_id_stage.sv
hw/segre_decode_top.sv
tests/segre_clkgen.sv
tests/segre_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps
TOP       = segre_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
PASS_MSG  = Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
